//--- source/cluster_bus_pkg.sv
/*
 * Bus-wide counts, target index encoding and the
 * single-beat request and response structs
 */

package cluster_bus_pkg;

  // Initiators are core data, core instruction, DMA and external
  localparam int unsigned NB_INIT    = 4;
  localparam int unsigned NB_TGT     = 3;
  localparam int unsigned INIT_IDX_W = 2;

  typedef enum logic [1:0] {
    TGT_TCDM   = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_EXT    = 2'd2
  } tgt_idx_t;

  // One request beat
  typedef struct packed {
    logic [31:0]           addr;
    logic                  we;
    logic [31:0]           wdata;
    logic [INIT_IDX_W-1:0] src;
  } bus_req_t;

  // One response beat, src names the initiator it returns to
  typedef struct packed {
    logic [31:0]           rdata;
    logic                  err;
    logic [INIT_IDX_W-1:0] src;
  } bus_resp_t;

endpackage

//--- source/cluster_addr_pkg.sv
/*
 * Cluster address map constants and the decode rule struct
 */

package cluster_addr_pkg;

  import cluster_bus_pkg::*;

  // Base of cluster 0, each further cluster is 4 MiB higher
  localparam logic [31:0]  CLUSTER_BASE         = 32'h1000_0000;
  localparam int unsigned  CLUSTER_STRIDE_SHIFT = 22;

  // Window offsets from the cluster base
  localparam logic [31:0]  PERIPH_OFFSET        = 32'h0020_0000;
  localparam logic [31:0]  EXT_OFFSET           = 32'h0040_0000;
  localparam logic [31:0]  ADDR_TOP             = 32'hFFFF_FFFF;

  // End is exclusive except in the last rule, which includes ADDR_TOP
  typedef struct packed {
    tgt_idx_t    idx;
    logic [31:0] start_addr;
    logic [31:0] end_addr;
  } addr_rule_t;

endpackage

//--- source/cluster_req_buffer.sv
/*
 * Circular valid/ready FIFO with a type parameter for its items
 */

`timescale 1ns/1ps

module cluster_req_buffer #(
  parameter type         item_t    = logic [31:0],
  parameter int unsigned BUF_DEPTH = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  logic  in_valid_i,
  output logic  in_ready_o,
  input  item_t in_data_i,
  output logic  out_valid_o,
  input  logic  out_ready_i,
  output item_t out_data_o
);

  localparam int unsigned      PTR_W    = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int unsigned      CNT_W    = $clog2(BUF_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(BUF_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(BUF_DEPTH);

  item_t            mem_q [BUF_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Valid comes straight from the fill count
  assign out_valid_o = (count_q != '0);
  // A full buffer still takes an item when the head leaves
  assign in_ready_o  = (count_q != FULL_CNT) || out_ready_i;
  assign push        = in_valid_i && in_ready_o;
  assign pop         = out_valid_o && out_ready_i;
  assign out_data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_data_i;
    end
  end

endmodule

//--- source/cluster_addr_decode.sv
/*
 * Address decoder with a rule table built from the cluster id,
 * steers a request to one target or turns it into an error response
 */

`timescale 1ns/1ps

module cluster_addr_decode
  import cluster_bus_pkg::*;
  import cluster_addr_pkg::*;
#(
  parameter int unsigned TCDM_SIZE = 32'h0001_0000
) (
  input  logic [5:0]        cluster_id_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  input  bus_req_t          req_i,
  output logic [NB_TGT-1:0] tgt_valid_o,
  input  logic [NB_TGT-1:0] tgt_ready_i,
  output bus_req_t          tgt_req_o,
  output logic              err_valid_o,
  input  logic              err_ready_i,
  output bus_resp_t         err_resp_o
);

  logic [31:0]              base_addr;
  addr_rule_t [NB_TGT-1:0]  rules;
  logic [NB_TGT-1:0]        sel;
  logic                     unmapped;

  assign base_addr = CLUSTER_BASE + ({26'd0, cluster_id_i} << CLUSTER_STRIDE_SHIFT);

  assign rules[0] = '{idx: TGT_TCDM, start_addr: base_addr,
                      end_addr: base_addr + 32'(TCDM_SIZE)};
  assign rules[1] = '{idx: TGT_PERIPH, start_addr: base_addr + PERIPH_OFFSET,
                      end_addr: base_addr + EXT_OFFSET};
  // Everything above the cluster window goes out
  assign rules[2] = '{idx: TGT_EXT, start_addr: base_addr + EXT_OFFSET,
                      end_addr: ADDR_TOP};

  always_comb begin
    sel = '0;
    for (int r = 0; r < NB_TGT; r++) begin
      if (req_i.addr >= rules[r].start_addr &&
          (req_i.addr < rules[r].end_addr ||
           (r == NB_TGT - 1 && req_i.addr == rules[r].end_addr))) begin
        sel[rules[r].idx] = 1'b1;
      end
    end
  end

  assign unmapped    = (sel == '0);

  // Windows do not overlap, so at most one target is selected
  assign tgt_valid_o = {NB_TGT{req_valid_i}} & sel;
  assign tgt_req_o   = req_i;

  // Unmapped requests never reach a target
  assign err_valid_o = req_valid_i && unmapped;
  assign err_resp_o  = '{rdata: '0, err: 1'b1, src: req_i.src};

  assign req_ready_o = unmapped ? err_ready_i : |(sel & tgt_ready_i);

endmodule

//--- source/cluster_target_arbiter.sv
/*
 * Round-robin arbiter for one target among the initiators
 */

`timescale 1ns/1ps

module cluster_target_arbiter
  import cluster_bus_pkg::*;
(
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic [NB_INIT-1:0]        req_valid_i,
  output logic [NB_INIT-1:0]        req_ready_o,
  input  bus_req_t [NB_INIT-1:0]    reqs_i,
  output logic                      tgt_valid_o,
  input  logic                      tgt_ready_i,
  output bus_req_t                  tgt_req_o
);

  // Search starts at rr_q, one past the last initiator served
  logic [INIT_IDX_W-1:0] rr_q;
  logic [INIT_IDX_W-1:0] cand;
  logic [INIT_IDX_W-1:0] gnt_idx;
  logic                  gnt_found;
  logic                  xfer;

  always_comb begin
    gnt_found = 1'b0;
    gnt_idx   = rr_q;
    cand      = rr_q;
    for (int k = 0; k < NB_INIT; k++) begin
      cand = INIT_IDX_W'((int'(rr_q) + k) % NB_INIT);
      if (!gnt_found && req_valid_i[cand]) begin
        gnt_found = 1'b1;
        gnt_idx   = cand;
      end
    end
  end

  assign tgt_valid_o = gnt_found;
  assign tgt_req_o   = reqs_i[gnt_idx];
  assign xfer        = gnt_found && tgt_ready_i;

  always_comb begin
    req_ready_o          = '0;
    req_ready_o[gnt_idx] = xfer;
  end

  // Pointer moves only on a completed transfer so a stalled grant holds
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rr_q <= '0;
    end else if (xfer) begin
      rr_q <= INIT_IDX_W'((int'(gnt_idx) + 1) % NB_INIT);
    end
  end

endmodule

//--- source/cluster_resp_router.sv
/*
 * Response router, per initiator a round robin over the three
 * target responses addressed to it and its own decode errors
 */

`timescale 1ns/1ps

module cluster_resp_router
  import cluster_bus_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [NB_TGT-1:0]          tgt_resp_valid_i,
  output logic [NB_TGT-1:0]          tgt_resp_ready_o,
  input  bus_resp_t [NB_TGT-1:0]     tgt_resp_i,
  input  logic [NB_INIT-1:0]         err_valid_i,
  output logic [NB_INIT-1:0]         err_ready_o,
  input  bus_resp_t [NB_INIT-1:0]    err_resp_i,
  output logic [NB_INIT-1:0]         init_resp_valid_o,
  input  logic [NB_INIT-1:0]         init_resp_ready_i,
  output bus_resp_t [NB_INIT-1:0]    init_resp_o
);

  // Sources 0..NB_TGT-1 are targets, the last one is the error path
  localparam int unsigned NB_SRC = NB_TGT + 1;
  localparam int unsigned SRC_W  = $clog2(NB_SRC);

  logic [NB_INIT-1:0][NB_TGT-1:0] tgt_take;

  for (genvar gi = 0; gi < NB_INIT; gi++) begin : g_init
    logic [NB_SRC-1:0]          src_valid;
    bus_resp_t [NB_SRC-1:0]     src_resp;
    logic [SRC_W-1:0]           rr_q;
    logic [SRC_W-1:0]           cand;
    logic [SRC_W-1:0]           gnt_idx;
    logic                       gnt_found;
    logic                       xfer;

    always_comb begin
      for (int j = 0; j < NB_TGT; j++) begin
        src_valid[j] = tgt_resp_valid_i[j] && (tgt_resp_i[j].src == INIT_IDX_W'(gi));
        src_resp[j]  = tgt_resp_i[j];
      end
      src_valid[NB_TGT] = err_valid_i[gi];
      src_resp[NB_TGT]  = err_resp_i[gi];
    end

    always_comb begin
      gnt_found = 1'b0;
      gnt_idx   = rr_q;
      cand      = rr_q;
      for (int k = 0; k < NB_SRC; k++) begin
        cand = SRC_W'((int'(rr_q) + k) % NB_SRC);
        if (!gnt_found && src_valid[cand]) begin
          gnt_found = 1'b1;
          gnt_idx   = cand;
        end
      end
    end

    assign init_resp_valid_o[gi] = gnt_found;
    assign init_resp_o[gi]       = src_resp[gnt_idx];
    assign xfer                  = gnt_found && init_resp_ready_i[gi];
    assign err_ready_o[gi]       = xfer && (gnt_idx == SRC_W'(NB_TGT));

    for (genvar gt = 0; gt < NB_TGT; gt++) begin : g_take
      assign tgt_take[gi][gt] = xfer && (gnt_idx == SRC_W'(gt));
    end

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        rr_q <= '0;
      end else if (xfer) begin
        rr_q <= SRC_W'((int'(gnt_idx) + 1) % NB_SRC);
      end
    end
  end

  // A target response names one initiator, so at most one takes it
  always_comb begin
    tgt_resp_ready_o = '0;
    for (int i = 0; i < NB_INIT; i++) begin
      tgt_resp_ready_o = tgt_resp_ready_o | tgt_take[i];
    end
  end

endmodule

//--- source/cluster_bus_top.sv
/*
 * Cluster interconnect top level, request buffers, address
 * decoders, target arbiters and the response router
 */

`timescale 1ns/1ps

module cluster_bus_top
  import cluster_bus_pkg::*;
#(
  // Keep at or below 2 MiB, the peripheral window starts there
  parameter int unsigned TCDM_SIZE = 32'h0001_0000,
  parameter int unsigned BUF_DEPTH = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [5:0]                 cluster_id_i,
  input  logic [NB_INIT-1:0]         init_req_valid_i,
  output logic [NB_INIT-1:0]         init_req_ready_o,
  input  bus_req_t [NB_INIT-1:0]     init_req_i,
  output logic [NB_INIT-1:0]         init_resp_valid_o,
  input  logic [NB_INIT-1:0]         init_resp_ready_i,
  output bus_resp_t [NB_INIT-1:0]    init_resp_o,
  output logic [NB_TGT-1:0]          tgt_req_valid_o,
  input  logic [NB_TGT-1:0]          tgt_req_ready_i,
  output bus_req_t [NB_TGT-1:0]      tgt_req_o,
  input  logic [NB_TGT-1:0]          tgt_resp_valid_i,
  output logic [NB_TGT-1:0]          tgt_resp_ready_o,
  input  bus_resp_t [NB_TGT-1:0]     tgt_resp_i
);

  bus_req_t [NB_INIT-1:0]            tagged_req;
  logic [NB_INIT-1:0]                buf_out_valid;
  logic [NB_INIT-1:0]                buf_out_ready;
  bus_req_t [NB_INIT-1:0]            buf_out_req;
  bus_req_t [NB_INIT-1:0]            dec_req;
  logic [NB_INIT-1:0][NB_TGT-1:0]    dec_tgt_valid;
  logic [NB_INIT-1:0][NB_TGT-1:0]    dec_tgt_ready;
  logic [NB_TGT-1:0][NB_INIT-1:0]    arb_req_valid;
  logic [NB_TGT-1:0][NB_INIT-1:0]    arb_req_ready;
  logic [NB_INIT-1:0]                err_valid;
  logic [NB_INIT-1:0]                err_ready;
  bus_resp_t [NB_INIT-1:0]           err_resp;

  for (genvar gi = 0; gi < NB_INIT; gi++) begin : g_init
    // Source field always carries the port the request came in on
    assign tagged_req[gi] = '{addr:  init_req_i[gi].addr,
                              we:    init_req_i[gi].we,
                              wdata: init_req_i[gi].wdata,
                              src:   INIT_IDX_W'(gi)};

    cluster_req_buffer #(
      .item_t    ( bus_req_t ),
      .BUF_DEPTH ( BUF_DEPTH )
    ) u_req_buf (
      .clk_i       ( clk_i                ),
      .rst_i       ( rst_i                ),
      .in_valid_i  ( init_req_valid_i[gi] ),
      .in_ready_o  ( init_req_ready_o[gi] ),
      .in_data_i   ( tagged_req[gi]       ),
      .out_valid_o ( buf_out_valid[gi]    ),
      .out_ready_i ( buf_out_ready[gi]    ),
      .out_data_o  ( buf_out_req[gi]      )
    );

    cluster_addr_decode #(
      .TCDM_SIZE ( TCDM_SIZE )
    ) u_decode (
      .cluster_id_i ( cluster_id_i       ),
      .req_valid_i  ( buf_out_valid[gi]  ),
      .req_ready_o  ( buf_out_ready[gi]  ),
      .req_i        ( buf_out_req[gi]    ),
      .tgt_valid_o  ( dec_tgt_valid[gi]  ),
      .tgt_ready_i  ( dec_tgt_ready[gi]  ),
      .tgt_req_o    ( dec_req[gi]        ),
      .err_valid_o  ( err_valid[gi]      ),
      .err_ready_i  ( err_ready[gi]      ),
      .err_resp_o   ( err_resp[gi]       )
    );
  end

  for (genvar gt = 0; gt < NB_TGT; gt++) begin : g_tgt
    // Turn decoder-major handshakes into arbiter-major ones
    for (genvar gi = 0; gi < NB_INIT; gi++) begin : g_xpose
      assign arb_req_valid[gt][gi] = dec_tgt_valid[gi][gt];
      assign dec_tgt_ready[gi][gt] = arb_req_ready[gt][gi];
    end

    cluster_target_arbiter u_arb (
      .clk_i       ( clk_i               ),
      .rst_i       ( rst_i               ),
      .req_valid_i ( arb_req_valid[gt]   ),
      .req_ready_o ( arb_req_ready[gt]   ),
      .reqs_i      ( dec_req             ),
      .tgt_valid_o ( tgt_req_valid_o[gt] ),
      .tgt_ready_i ( tgt_req_ready_i[gt] ),
      .tgt_req_o   ( tgt_req_o[gt]       )
    );
  end

  cluster_resp_router u_router (
    .clk_i             ( clk_i             ),
    .rst_i             ( rst_i             ),
    .tgt_resp_valid_i  ( tgt_resp_valid_i  ),
    .tgt_resp_ready_o  ( tgt_resp_ready_o  ),
    .tgt_resp_i        ( tgt_resp_i        ),
    .err_valid_i       ( err_valid         ),
    .err_ready_o       ( err_ready         ),
    .err_resp_i        ( err_resp          ),
    .init_resp_valid_o ( init_resp_valid_o ),
    .init_resp_ready_i ( init_resp_ready_i ),
    .init_resp_o       ( init_resp_o       )
  );

endmodule

//--- dv/cluster_bus_model.svh
/*
 * Reference address decode, expected response values and the
 * expected-value queues for the cluster interconnect testbench
 */

`ifndef CLUSTER_BUS_MODEL_SVH
`define CLUSTER_BUS_MODEL_SVH

localparam int unsigned MODEL_TCDM_SIZE = 32'h0001_0000;
localparam logic [31:0] RDATA_KEY       = 32'h5A5A_5A5A;
// Source slot of decode errors, after the three targets
localparam int unsigned ERR_SRC         = NB_TGT;

// Requests still to reach a target, per target and initiator
bus_req_t  exp_req_q  [NB_TGT][NB_INIT][$];
// Responses still to reach an initiator, per initiator and source
bus_resp_t exp_resp_q [NB_INIT][NB_TGT+1][$];

// Returns 0 for TCDM, 1 for peripherals, 2 for external, 3 if unmapped
function automatic int unsigned ref_decode(input logic [5:0] cid, input logic [31:0] addr);
  logic [31:0] base;
  base = 32'h1000_0000 + (32'(cid) << 22);
  if (addr >= base && addr < base + MODEL_TCDM_SIZE) begin
    return 0;
  end
  if (addr >= base + 32'h0020_0000 && addr < base + 32'h0040_0000) begin
    return 1;
  end
  // External runs up to the top of memory inclusive
  if (addr >= base + 32'h0040_0000) begin
    return 2;
  end
  return ERR_SRC;
endfunction

function automatic bus_resp_t ref_resp(input bus_req_t r);
  return '{rdata: r.addr ^ RDATA_KEY, err: 1'b0, src: r.src};
endfunction

function automatic bus_resp_t ref_err_resp(input int unsigned src);
  return '{rdata: 32'd0, err: 1'b1, src: INIT_IDX_W'(src)};
endfunction

`endif

//--- dv/cluster_bus_tb.sv
/*
 * Cluster interconnect testbench with random traffic, target
 * responders, a TCDM fairness phase and the closing report
 */

`timescale 1ns/1ps

module cluster_bus_tb
  import cluster_bus_pkg::*;
();

  `include "cluster_bus_model.svh"

  localparam int unsigned RAND_PER_INIT = 80;
  localparam int unsigned FAIR_PER_INIT = 20;
  localparam int unsigned TOTAL_REQS    = NB_INIT * (RAND_PER_INIT + FAIR_PER_INIT);
  // At most 40 cycles per request
  localparam int unsigned MAX_CYCLES    = TOTAL_REQS * 40;

  logic                    clk;
  logic                    rst;
  logic [5:0]              cluster_id;
  logic [NB_INIT-1:0]      req_valid;
  logic [NB_INIT-1:0]      req_ready;
  bus_req_t [NB_INIT-1:0]  req;
  logic [NB_INIT-1:0]      resp_valid;
  logic [NB_INIT-1:0]      resp_ready;
  bus_resp_t [NB_INIT-1:0] resp;
  logic [NB_TGT-1:0]       tgt_valid;
  logic [NB_TGT-1:0]       tgt_ready;
  bus_req_t [NB_TGT-1:0]   tgt_req;
  logic [NB_TGT-1:0]       tgt_resp_valid;
  logic [NB_TGT-1:0]       tgt_resp_ready;
  bus_resp_t [NB_TGT-1:0]  tgt_resp;

  integer                  seed;
  int unsigned             cycle_cnt;
  int unsigned             issued_cnt;
  int unsigned             resp_cnt;
  int unsigned             value_err_cnt;
  int unsigned             flow_err_cnt;
  int unsigned             budget [NB_INIT];
  int unsigned             grants_since [NB_INIT];
  int unsigned             valid_pct;
  int unsigned             ready_pct;
  logic                    fair_phase;
  logic [NB_INIT-1:0]      req_taken;
  logic [NB_TGT-1:0]       resp_taken;
  // Requests each target has accepted and not yet answered
  bus_req_t                tgt_pend_q [NB_TGT][$];

  cluster_bus_top #(
    .TCDM_SIZE ( MODEL_TCDM_SIZE ),
    .BUF_DEPTH ( 4 )
  ) u_dut (
    .clk_i             ( clk            ),
    .rst_i             ( rst            ),
    .cluster_id_i      ( cluster_id     ),
    .init_req_valid_i  ( req_valid      ),
    .init_req_ready_o  ( req_ready      ),
    .init_req_i        ( req            ),
    .init_resp_valid_o ( resp_valid     ),
    .init_resp_ready_i ( resp_ready     ),
    .init_resp_o       ( resp           ),
    .tgt_req_valid_o   ( tgt_valid      ),
    .tgt_req_ready_i   ( tgt_ready      ),
    .tgt_req_o         ( tgt_req        ),
    .tgt_resp_valid_i  ( tgt_resp_valid ),
    .tgt_resp_ready_o  ( tgt_resp_ready ),
    .tgt_resp_i        ( tgt_resp       )
  );

  always #4 clk = ~clk;

  function automatic int unsigned rand_below(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  // Mostly the three windows and some addresses outside the map
  function automatic logic [31:0] pick_addr(input logic tcdm_only);
    logic [31:0] base;
    logic [31:0] rnd;
    int unsigned kind;
    base = 32'h1000_0000 + (32'(cluster_id) << 22);
    rnd  = $random(seed);
    kind = tcdm_only ? 0 : rand_below(100);
    if (kind < 40) begin
      return base + (rnd & 32'h0000_FFFC);
    end else if (kind < 60) begin
      return base + 32'h0020_0000 + (rnd & 32'h001F_FFFC);
    end else if (kind < 76) begin
      return base + 32'h0040_0000 + (rnd & 32'h0FFF_FFFC);
    end else if (kind < 78) begin
      return 32'hFFFF_FFFC;
    end else if (kind < 90) begin
      // Below the lowest cluster base
      return rnd & 32'h0FFF_FFFC;
    end
    // Hole between TCDM and the peripherals
    return base + 32'h0001_0000 + (rnd & 32'h0000_FFFC);
  endfunction

  task automatic drive_inputs();
    bus_req_t head;
    for (int i = 0; i < NB_INIT; i++) begin
      if (req_valid[i] && req_taken[i]) begin
        req_valid[i] = 1'b0;
      end
      req_taken[i] = 1'b0;
      if (!req_valid[i] && budget[i] != 0 && rand_below(100) < valid_pct) begin
        req[i].addr  = pick_addr(fair_phase);
        req[i].we    = (rand_below(100) < 30);
        req[i].wdata = $random(seed);
        // Junk source that the top level replaces
        req[i].src   = INIT_IDX_W'(rand_below(NB_INIT));
        req_valid[i] = 1'b1;
        budget[i]    = budget[i] - 1;
      end
      resp_ready[i] = (rand_below(100) < 75);
    end
    for (int t = 0; t < NB_TGT; t++) begin
      if (tgt_resp_valid[t] && resp_taken[t]) begin
        tgt_resp_valid[t] = 1'b0;
        void'(tgt_pend_q[t].pop_front());
      end
      resp_taken[t] = 1'b0;
      // Random response delay with answers in acceptance order
      if (!tgt_resp_valid[t] && tgt_pend_q[t].size() != 0 && rand_below(100) < 50) begin
        head              = tgt_pend_q[t][0];
        tgt_resp[t].rdata = head.addr ^ RDATA_KEY;
        tgt_resp[t].err   = 1'b0;
        tgt_resp[t].src   = head.src;
        tgt_resp_valid[t] = 1'b1;
      end
      tgt_ready[t] = (rand_below(100) < ready_pct);
    end
  endtask

  // No initiator may see four other TCDM grants while it waits
  task automatic update_fairness(input int unsigned winner, input logic [NB_INIT-1:0] pending);
    for (int i = 0; i < NB_INIT; i++) begin
      if (i == int'(winner) || !pending[i]) begin
        grants_since[i] = 0;
      end else begin
        grants_since[i]++;
        assert (grants_since[i] < NB_INIT) else begin
          $display("Error at %0t: initiator %0d passed over for %0d TCDM grants",
                   $time, i, grants_since[i]);
          flow_err_cnt++;
        end
      end
    end
  endtask

  task automatic check_tgt_reqs();
    bus_req_t           got;
    bus_req_t           exp;
    int unsigned        src;
    logic [NB_INIT-1:0] pending;
    for (int i = 0; i < NB_INIT; i++) begin
      pending[i] = (exp_req_q[0][i].size() != 0);
    end
    for (int t = 0; t < NB_TGT; t++) begin
      if (tgt_valid[t] && tgt_ready[t]) begin
        got = tgt_req[t];
        src = got.src;
        assert (ref_decode(cluster_id, got.addr) == t) else begin
          $display("Error at %0t: target %0d took address %h", $time, t, got.addr);
          value_err_cnt++;
        end
        assert (exp_req_q[t][src].size() != 0) else begin
          $display("Error at %0t: target %0d got an unexpected request from %0d",
                   $time, t, src);
          flow_err_cnt++;
        end
        if (exp_req_q[t][src].size() != 0) begin
          exp = exp_req_q[t][src].pop_front();
          assert (got == exp) else begin
            $display("Error at %0t: target %0d request %h, expected %h", $time, t, got, exp);
            value_err_cnt++;
          end
          exp_resp_q[src][t].push_back(ref_resp(exp));
        end
        tgt_pend_q[t].push_back(got);
        if (fair_phase && t == 0) begin
          update_fairness(src, pending);
        end
      end
    end
  endtask

  task automatic check_init_resps();
    bus_resp_t   got;
    bus_resp_t   exp;
    int unsigned sel;
    for (int i = 0; i < NB_INIT; i++) begin
      if (resp_valid[i] && resp_ready[i]) begin
        got = resp[i];
        resp_cnt++;
        // Read data leads back to the address and so to the target
        sel = got.err ? ERR_SRC : ref_decode(cluster_id, got.rdata ^ RDATA_KEY);
        assert ((got.err || sel != ERR_SRC) && exp_resp_q[i][sel].size() != 0) else begin
          $display("Error at %0t: initiator %0d got unexpected response %h", $time, i, got);
          flow_err_cnt++;
        end
        if ((got.err || sel != ERR_SRC) && exp_resp_q[i][sel].size() != 0) begin
          exp = exp_resp_q[i][sel].pop_front();
          assert (got == exp) else begin
            $display("Error at %0t: initiator %0d response %h, expected %h",
                     $time, i, got, exp);
            value_err_cnt++;
          end
        end
      end
    end
  endtask

  task automatic record_issues();
    bus_req_t    acc;
    int unsigned t;
    for (int i = 0; i < NB_INIT; i++) begin
      if (req_valid[i] && req_ready[i]) begin
        acc     = req[i];
        acc.src = INIT_IDX_W'(i);
        t       = ref_decode(cluster_id, acc.addr);
        if (t == ERR_SRC) begin
          exp_resp_q[i][ERR_SRC].push_back(ref_err_resp(i));
        end else begin
          exp_req_q[t][i].push_back(acc);
        end
        issued_cnt++;
        req_taken[i] = 1'b1;
      end
    end
  endtask

  // Handshakes complete on the rising edge
  always @(posedge clk) begin
    if (!rst) begin
      check_tgt_reqs();
      check_init_resps();
      resp_taken = resp_taken | (tgt_resp_valid & tgt_resp_ready);
      record_issues();
    end
  end

  task automatic run_phase(input int unsigned per_init, input int unsigned v_pct,
                           input int unsigned r_pct, input logic fair);
    fair_phase = fair;
    valid_pct  = v_pct;
    ready_pct  = r_pct;
    for (int i = 0; i < NB_INIT; i++) begin
      budget[i]       = per_init;
      grants_since[i] = 0;
    end
    do begin
      @(negedge clk);
      drive_inputs();
    end while (!(budget.sum() == 0 && req_valid == '0 && issued_cnt == resp_cnt));
  endtask

  task automatic check_drained();
    int unsigned left;
    left = 0;
    for (int t = 0; t < NB_TGT; t++) begin
      left += tgt_pend_q[t].size();
    end
    for (int i = 0; i < NB_INIT; i++) begin
      for (int s = 0; s <= NB_TGT; s++) begin
        left += exp_resp_q[i][s].size();
        if (s < NB_TGT) begin
          left += exp_req_q[s][i].size();
        end
      end
    end
    assert (left == 0 && issued_cnt == TOTAL_REQS && resp_cnt == TOTAL_REQS) else begin
      $display("Error at %0t: %0d items outstanding, %0d issued, %0d answered",
               $time, left, issued_cnt, resp_cnt);
      flow_err_cnt++;
    end
  endtask

  task automatic print_summary();
    $display("Summary: %0d value errors, %0d flow errors, %0d requests, %0d responses",
             value_err_cnt, flow_err_cnt, issued_cnt, resp_cnt);
  endtask

  initial begin
    seed           = 32'he32ae5d0;
    clk            = 1'b0;
    rst            = 1'b1;
    req_valid      = '0;
    req            = '0;
    resp_ready     = '0;
    tgt_ready      = '0;
    tgt_resp_valid = '0;
    tgt_resp       = '0;
    req_taken      = '0;
    resp_taken     = '0;
    fair_phase     = 1'b0;
    valid_pct      = 0;
    ready_pct      = 0;
    issued_cnt     = 0;
    resp_cnt       = 0;
    value_err_cnt  = 0;
    flow_err_cnt   = 0;
    for (int i = 0; i < NB_INIT; i++) begin
      budget[i]       = 0;
      grants_since[i] = 0;
    end
    cluster_id = 6'($unsigned($random(seed)));
    // Requests offered while in reset must not survive it
    for (int i = 0; i < NB_INIT; i++) begin
      req[i].addr = pick_addr(1'b0);
    end
    req_valid = '1;
    repeat (9) @(negedge clk);
    req_valid = '0;
    @(negedge clk);
    rst = 1'b0;
    assert (tgt_valid == '0 && resp_valid == '0) else begin
      $display("Error at %0t: valid high after reset, targets %b initiators %b",
               $time, tgt_valid, resp_valid);
      value_err_cnt++;
    end
    run_phase(RAND_PER_INIT, 60, 70, 1'b0);
    // All initiators flood the TCDM
    run_phase(FAIR_PER_INIT, 100, 60, 1'b1);
    repeat (20) begin
      @(negedge clk);
      drive_inputs();
    end
    check_drained();
    print_summary();
    if (value_err_cnt == 0 && flow_err_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: traffic did not drain within %0d cycles", MAX_CYCLES);
    print_summary();
    $display("TEST FAIL");
    $finish;
  end

endmodule

//--- cluster_bus_top.f
source/cluster_bus_pkg.sv
source/cluster_addr_pkg.sv
source/cluster_req_buffer.sv
source/cluster_addr_decode.sv
source/cluster_target_arbiter.sv
source/cluster_resp_router.sv
source/cluster_bus_top.sv
+incdir+dv
dv/cluster_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the cluster interconnect testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
  --top-module cluster_bus_tb -Mdir "$OBJ" -o cluster_bus_sim \
  -f cluster_bus_top.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$OBJ/cluster_bus_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
fi
exit 1
